// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_riscv_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic              clk,
    input  logic              reset_i,
    input  rv_pkg::xlen_t     if_pc_i,
    input  rv_pkg::inst_t     if_inst_i,
    input  logic              flush_i,
    input  rv_pkg::xlen_t     rdata1_i,
    input  rv_pkg::xlen_t     rdata2_i,
    input  rv_pkg::wb_t       ex_fwd_i,
    input  rv_pkg::wb_t       wb_fwd_i,
    output rv_pkg::reg_addr_t raddr1_o,
    output rv_pkg::reg_addr_t raddr2_o,
    output rv_pkg::id_ex_t    id_ex_o
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    rv_pkg::xlen_t     imm_i;
    rv_pkg::xlen_t     imm_s;
    rv_pkg::xlen_t     imm_b;
    rv_pkg::xlen_t     imm_u;
    rv_pkg::xlen_t     imm_j;
    rv_pkg::id_ex_t    id_ex_d;

    // newest producer wins: execute, then writeback, then the register file
    function automatic rv_pkg::xlen_t fwd_operand(
        input rv_pkg::reg_addr_t addr,
        input rv_pkg::xlen_t     rf_data,
        input rv_pkg::wb_t       ex_fwd,
        input rv_pkg::wb_t       wb_fwd
    );
        rv_pkg::xlen_t val;
        if (ex_fwd.wreg && (ex_fwd.rd == addr)) begin
            val = ex_fwd.wdata;
        end else if (wb_fwd.wreg && (wb_fwd.rd == addr)) begin
            val = wb_fwd.wdata;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign opcode = if_inst_i[6:0];
    assign funct3 = if_inst_i[14:12];
    assign funct7 = if_inst_i[31:25];
    assign rs1    = if_inst_i[19:15];
    assign rs2    = if_inst_i[24:20];
    assign rd     = if_inst_i[11:7];

    // immediate formats
    assign imm_i = {{20{if_inst_i[31]}}, if_inst_i[31:20]};
    assign imm_s = {{20{if_inst_i[31]}}, if_inst_i[31:25], if_inst_i[11:7]};
    assign imm_b = {{19{if_inst_i[31]}}, if_inst_i[31], if_inst_i[7],
                    if_inst_i[30:25], if_inst_i[11:8], 1'b0};
    assign imm_u = {if_inst_i[31:12], 12'b0};
    assign imm_j = {{11{if_inst_i[31]}}, if_inst_i[31], if_inst_i[19:12],
                    if_inst_i[20], if_inst_i[30:21], 1'b0};

    assign raddr1_o = rs1;
    assign raddr2_o = rs2;

    always_comb begin
        id_ex_d.pc       = if_pc_i;
        id_ex_d.op_a     = fwd_operand(rs1, rdata1_i, ex_fwd_i, wb_fwd_i);
        id_ex_d.op_b     = fwd_operand(rs2, rdata2_i, ex_fwd_i, wb_fwd_i);
        id_ex_d.imm      = imm_i;
        id_ex_d.alu_op   = rv_pkg::ALU_ADD;
        id_ex_d.use_imm  = 1'b0;
        id_ex_d.br_kind  = rv_pkg::BR_NONE;
        id_ex_d.is_store = 1'b0;
        id_ex_d.rd       = rd;
        id_ex_d.wreg     = 1'b0;
        case (opcode)
            rv_pkg::OPC_LUI: begin
                id_ex_d.alu_op  = rv_pkg::ALU_LUI;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.imm     = imm_u;
                id_ex_d.wreg    = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                id_ex_d.use_imm = 1'b1;
                id_ex_d.wreg    = 1'b1;
                case (funct3)
                    3'b000:  id_ex_d.alu_op = rv_pkg::ALU_ADD;
                    3'b010:  id_ex_d.alu_op = rv_pkg::ALU_SLT;
                    3'b100:  id_ex_d.alu_op = rv_pkg::ALU_XOR;
                    3'b110:  id_ex_d.alu_op = rv_pkg::ALU_OR;
                    3'b111:  id_ex_d.alu_op = rv_pkg::ALU_AND;
                    // shifts and sltiu are not supported
                    default: id_ex_d.wreg = 1'b0;
                endcase
            end
            rv_pkg::OPC_OP: begin
                id_ex_d.wreg = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: id_ex_d.alu_op = rv_pkg::ALU_ADD;
                    {7'b0100000, 3'b000}: id_ex_d.alu_op = rv_pkg::ALU_SUB;
                    {7'b0000000, 3'b001}: id_ex_d.alu_op = rv_pkg::ALU_SLL;
                    {7'b0000000, 3'b010}: id_ex_d.alu_op = rv_pkg::ALU_SLT;
                    {7'b0000000, 3'b100}: id_ex_d.alu_op = rv_pkg::ALU_XOR;
                    {7'b0000000, 3'b101}: id_ex_d.alu_op = rv_pkg::ALU_SRL;
                    {7'b0100000, 3'b101}: id_ex_d.alu_op = rv_pkg::ALU_SRA;
                    {7'b0000000, 3'b110}: id_ex_d.alu_op = rv_pkg::ALU_OR;
                    {7'b0000000, 3'b111}: id_ex_d.alu_op = rv_pkg::ALU_AND;
                    default:              id_ex_d.wreg   = 1'b0;
                endcase
            end
            rv_pkg::OPC_BRANCH: begin
                id_ex_d.imm = imm_b;
                case (funct3)
                    3'b000:  id_ex_d.br_kind = rv_pkg::BR_EQ;
                    3'b001:  id_ex_d.br_kind = rv_pkg::BR_NE;
                    3'b100:  id_ex_d.br_kind = rv_pkg::BR_LT;
                    3'b101:  id_ex_d.br_kind = rv_pkg::BR_GE;
                    default: id_ex_d.br_kind = rv_pkg::BR_NONE;
                endcase
            end
            rv_pkg::OPC_JAL: begin
                id_ex_d.imm     = imm_j;
                id_ex_d.br_kind = rv_pkg::BR_JAL;
                id_ex_d.wreg    = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                // address is rs1 + imm through the adder
                id_ex_d.imm      = imm_s;
                id_ex_d.use_imm  = 1'b1;
                id_ex_d.is_store = (funct3 == 3'b010);
            end
            default: begin
                id_ex_d.wreg = 1'b0;
            end
        endcase
        // x0 results never reach forwarding or the register file
        if (rd == '0) begin
            id_ex_d.wreg = 1'b0;
        end
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        id_ex_o <= id_ex_d;
        if (reset_i || flush_i) begin
            id_ex_o.wreg     <= 1'b0;
            id_ex_o.is_store <= 1'b0;
            id_ex_o.br_kind  <= rv_pkg::BR_NONE;
        end
    end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic           clk,
    input  logic           reset_i,
    input  rv_pkg::id_ex_t id_ex_i,
    output logic           br_taken_o,
    output rv_pkg::xlen_t  br_target_o,
    output rv_pkg::wb_t    ex_fwd_o,
    output rv_pkg::wb_t    wb_o,
    output logic           dmem_we_o,
    output rv_pkg::xlen_t  dmem_addr_o,
    output rv_pkg::xlen_t  dmem_wdata_o
);

    rv_pkg::xlen_t alu_b;
    rv_pkg::xlen_t alu_res;
    rv_pkg::xlen_t link_pc;

    assign alu_b   = id_ex_i.use_imm ? id_ex_i.imm : id_ex_i.op_b;
    assign link_pc = id_ex_i.pc + 32'd4;

    always_comb begin
        case (id_ex_i.alu_op)
            rv_pkg::ALU_ADD: alu_res = id_ex_i.op_a + alu_b;
            rv_pkg::ALU_SUB: alu_res = id_ex_i.op_a - alu_b;
            rv_pkg::ALU_AND: alu_res = id_ex_i.op_a & alu_b;
            rv_pkg::ALU_OR:  alu_res = id_ex_i.op_a | alu_b;
            rv_pkg::ALU_XOR: alu_res = id_ex_i.op_a ^ alu_b;
            rv_pkg::ALU_SLT: alu_res = {31'b0, $signed(id_ex_i.op_a) < $signed(alu_b)};
            rv_pkg::ALU_SLL: alu_res = id_ex_i.op_a << alu_b[4:0];
            rv_pkg::ALU_SRL: alu_res = id_ex_i.op_a >> alu_b[4:0];
            rv_pkg::ALU_SRA: alu_res = $signed(id_ex_i.op_a) >>> alu_b[4:0];
            rv_pkg::ALU_LUI: alu_res = alu_b;
            default:         alu_res = '0;
        endcase
    end

    // branch compare always uses the two register operands
    always_comb begin
        case (id_ex_i.br_kind)
            rv_pkg::BR_EQ:  br_taken_o = (id_ex_i.op_a == id_ex_i.op_b);
            rv_pkg::BR_NE:  br_taken_o = (id_ex_i.op_a != id_ex_i.op_b);
            rv_pkg::BR_LT:  br_taken_o = ($signed(id_ex_i.op_a) < $signed(id_ex_i.op_b));
            rv_pkg::BR_GE:  br_taken_o = ($signed(id_ex_i.op_a) >= $signed(id_ex_i.op_b));
            rv_pkg::BR_JAL: br_taken_o = 1'b1;
            default:        br_taken_o = 1'b0;
        endcase
    end

    assign br_target_o = id_ex_i.pc + id_ex_i.imm;

    // unregistered result, seen by decode for forwarding
    always_comb begin
        ex_fwd_o.wreg  = id_ex_i.wreg;
        ex_fwd_o.rd    = id_ex_i.rd;
        ex_fwd_o.wdata = (id_ex_i.br_kind == rv_pkg::BR_JAL) ? link_pc : alu_res;
    end

    // writeback register and store port
    always_ff @(posedge clk) begin
        wb_o         <= ex_fwd_o;
        dmem_addr_o  <= alu_res;
        dmem_wdata_o <= id_ex_i.op_b;
        if (reset_i) begin
            wb_o.wreg <= 1'b0;
            dmem_we_o <= 1'b0;
        end else begin
            dmem_we_o <= id_ex_i.is_store;
        end
    end

    // back-to-back pulses must come from two different store instructions
    a_store_single: assert property (@(posedge clk) disable iff (reset_i)
        (dmem_we_o && $past(dmem_we_o)) |-> ($past(id_ex_i.pc, 1) != $past(id_ex_i.pc, 2)))
        else $error("execute_stage: one store held dmem_we_o for two cycles");

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
    parameter rv_pkg::xlen_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          br_taken_i,
    input  rv_pkg::xlen_t br_target_i,
    input  rv_pkg::inst_t imem_data_i,
    output rv_pkg::xlen_t pc_o,
    output rv_pkg::xlen_t if_pc_o,
    output rv_pkg::inst_t if_inst_o
);

    rv_pkg::xlen_t pc_q;

    // program counter, redirect wins over sequential fetch
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (br_taken_i) begin
            pc_q <= br_target_i;
        end else begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // instruction port is combinational, address is the live pc
    assign pc_o = pc_q;

    // IF/ID register
    always_ff @(posedge clk) begin
        if_pc_o <= pc_q;
        if (reset_i || br_taken_i) begin
            // wrong-path fetch becomes a bubble
            if_inst_o <= rv_pkg::INST_NOP;
        end else begin
            if_inst_o <= imem_data_i;
        end
    end

    // targets come from execute, so this covers the whole redirect path
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
        pc_q[1:0] == 2'b00)
        else $error("fetch_unit: misaligned pc %h", pc_q);

endmodule

// File: design/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic              clk,
    input  logic              reset_i,
    input  rv_pkg::wb_t       wb_i,
    input  rv_pkg::reg_addr_t raddr1_i,
    input  rv_pkg::reg_addr_t raddr2_i,
    output rv_pkg::xlen_t     rdata1_o,
    output rv_pkg::xlen_t     rdata2_o
);

    // x0 is cleared on reset and never written afterwards
    rv_pkg::xlen_t regs [0:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs[0] <= '0;
        end else if (wb_i.wreg && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.wdata;
        end
    end

    // reads are combinational
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

    // x0 reads as zero on both ports, whatever was written before
    a_x0_zero: assert property (@(posedge clk) disable iff (reset_i)
        ((raddr1_i != '0) || (rdata1_o == '0)) &&
        ((raddr2_i != '0) || (rdata2_o == '0)))
        else $error("reg_file: x0 read back non-zero");

endmodule

// File: design/riscv_core.sv
`timescale 1ns/10ps

module riscv_core #(
    parameter rv_pkg::xlen_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          reset_i,
    output rv_pkg::xlen_t imem_addr_o,
    input  rv_pkg::inst_t imem_data_i,
    output logic          dmem_we_o,
    output rv_pkg::xlen_t dmem_addr_o,
    output rv_pkg::xlen_t dmem_wdata_o
);

    // IF/ID
    rv_pkg::xlen_t     if_pc;
    rv_pkg::inst_t     if_inst;

    // redirect from execute
    logic              br_taken;
    rv_pkg::xlen_t     br_target;

    // register file read ports
    rv_pkg::reg_addr_t raddr1;
    rv_pkg::reg_addr_t raddr2;
    rv_pkg::xlen_t     rdata1;
    rv_pkg::xlen_t     rdata2;

    rv_pkg::id_ex_t    id_ex;
    rv_pkg::wb_t       ex_fwd;
    rv_pkg::wb_t       wb;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk         (clk),
        .reset_i     (reset_i),
        .br_taken_i  (br_taken),
        .br_target_i (br_target),
        .imem_data_i (imem_data_i),
        .pc_o        (imem_addr_o),
        .if_pc_o     (if_pc),
        .if_inst_o   (if_inst)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_i     (wb),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    decode_stage u_decode_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .if_pc_i   (if_pc),
        .if_inst_i (if_inst),
        .flush_i   (br_taken),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .ex_fwd_i  (ex_fwd),
        .wb_fwd_i  (wb),
        .raddr1_o  (raddr1),
        .raddr2_o  (raddr2),
        .id_ex_o   (id_ex)
    );

    execute_stage u_execute_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .id_ex_i      (id_ex),
        .br_taken_o   (br_taken),
        .br_target_o  (br_target),
        .ex_fwd_o     (ex_fwd),
        .wb_o         (wb),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o)
    );

endmodule

// File: design/rv_pkg.sv
package rv_pkg;

    // data word or address
    typedef logic [31:0] xlen_t;

    // register index
    typedef logic [4:0] reg_addr_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // addi x0, x0, 0
    localparam inst_t INST_NOP = 32'h0000_0013;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_JAL
    } br_kind_t;

    // decode to execute
    typedef struct packed {
        xlen_t     pc;
        xlen_t     op_a;
        xlen_t     op_b;
        xlen_t     imm;
        alu_op_t   alu_op;
        logic      use_imm;
        br_kind_t  br_kind;
        logic      is_store;
        reg_addr_t rd;
        logic      wreg;
    } id_ex_t;

    // writeback bus, also used for forwarding
    typedef struct packed {
        logic      wreg;
        reg_addr_t rd;
        xlen_t     wdata;
    } wb_t;

endpackage

// File: sources.f
+incdir+tests
design/rv_pkg.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/riscv_core.sv
tests/tb_riscv_core.sv

// File: tests/tb_rv_encode.svh
`ifndef TB_RV_ENCODE_SVH
`define TB_RV_ENCODE_SVH

// register-register op
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

// register-immediate op
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
endfunction

// sw rs2, imm(rs1)
function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

// byte offset, bit 0 is implied zero
function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_jal(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// fn is {funct7[5], funct3}, immediate forms use fn[3] = 0
function automatic logic [31:0] golden_alu(input logic [3:0] fn, input logic [31:0] a,
        input logic [31:0] b);
    logic [31:0] r;
    case (fn)
        4'b0000: r = a + b;
        4'b1000: r = a - b;
        4'b0001: r = a << b[4:0];
        4'b0010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        4'b0100: r = a ^ b;
        4'b0101: r = a >> b[4:0];
        4'b1101: r = $unsigned($signed(a) >>> b[4:0]);
        4'b0110: r = a | b;
        4'b0111: r = a & b;
        default: r = 32'd0;
    endcase
    return r;
endfunction

`endif

// File: tests/tb_riscv_core.sv
`timescale 1ns/10ps

module tb_riscv_core;

    localparam logic [31:0] RESET_PC      = 32'h0000_0000;
    localparam logic [31:0] STORE_BASE    = 32'h1000_0000;
    localparam int          IMEM_WORDS    = 256;
    localparam int          STORE_TIMEOUT = 1000;
    localparam logic [31:0] SEED          = 32'h39d2f228;

    logic        clk;
    logic        reset_i;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;

    logic [31:0] imem [IMEM_WORDS];
    // sequential register model
    logic [31:0] xr [32];
    logic [31:0] store_addr_q [$];
    logic [31:0] store_data_q [$];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    int          wp;
    logic [11:0] st_off;
    int          err_count;
    int          check_count;
    int unsigned seed_dummy;

    `include "tb_rv_encode.svh"

    riscv_core #(
        .RESET_PC (RESET_PC)
    ) u_riscv_core (
        .clk          (clk),
        .reset_i      (reset_i),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_we_o    (dmem_we),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata)
    );

    always #2 clk = ~clk;

    assign imem_data = imem[imem_addr[9:2]];

    // store monitor
    always @(posedge clk) begin
        if (!reset_i && dmem_we) begin
            store_addr_q.push_back(dmem_addr);
            store_data_q.push_back(dmem_wdata);
        end
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR: %0t ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
            input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    // harmless addi x0 with the word index as immediate
    task automatic fill_imem();
        int i;
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0);
        end
    endtask

    task automatic emit(input logic [31:0] inst);
        imem[wp] = inst;
        wp++;
    endtask

    task automatic emit_li(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;
        emit(enc_lui(hi[31:12], rd));
        emit(enc_i(value[11:0], rd, 3'b000, rd));
        if (rd != 5'd0) begin
            xr[rd] = value;
        end
    endtask

    task automatic emit_op_reg(input logic [3:0] fn, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2);
        emit(enc_r({1'b0, fn[3], 5'b0}, rs2, rs1, fn[2:0], rd));
        if (rd != 5'd0) begin
            xr[rd] = golden_alu(fn, xr[rs1], xr[rs2]);
        end
    endtask

    task automatic emit_op_imm(input logic [2:0] f3, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [11:0] imm);
        emit(enc_i(imm, rs1, f3, rd));
        if (rd != 5'd0) begin
            xr[rd] = golden_alu({1'b0, f3}, xr[rs1], {{20{imm[11]}}, imm});
        end
    endtask

    // stores off x31; wrong-path stores still use up an offset
    task automatic emit_store(input logic [4:0] rs2, input logic on_path);
        emit(enc_sw(st_off, rs2, 5'd31));
        if (on_path) begin
            exp_addr_q.push_back(STORE_BASE + {20'b0, st_off});
            exp_data_q.push_back(xr[rs2]);
        end
        st_off = st_off + 12'd4;
    endtask

    task automatic begin_program();
        @(posedge clk);
        reset_i <= 1'b1;
        @(posedge clk);
        fill_imem();
        exp_addr_q.delete();
        exp_data_q.delete();
        wp     = 0;
        st_off = 12'd0;
        emit_li(5'd31, STORE_BASE);
    endtask

    task automatic wait_stores(input int n);
        int cycles;
        cycles = 0;
        while ((store_addr_q.size() < n) && (cycles < STORE_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
        end
        if (store_addr_q.size() < n) begin
            $display("timeout: waited %0d cycles for %0d stores, saw only %0d",
                     cycles, n, store_addr_q.size());
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic run_program();
        int i;
        emit(enc_jal(21'd0, 5'd0));
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_eq({31'b0, dmem_we}, 32'd0, "dmem_we_o while in reset");
        end
        store_addr_q.delete();
        store_data_q.delete();
        @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_eq(imem_addr, RESET_PC, "first fetch address after reset");
        check_eq({31'b0, dmem_we}, 32'd0, "dmem_we_o right after reset");
        wait_stores(exp_addr_q.size());
        // four stages deep, so any stray store shows up within this
        repeat (6) @(negedge clk);
        check_eq(32'(store_addr_q.size()), 32'(exp_addr_q.size()), "number of stores");
        for (i = 0; (i < exp_addr_q.size()) && (i < store_addr_q.size()); i++) begin
            check_eq(store_addr_q[i], exp_addr_q[i], $sformatf("store %0d address", i));
            check_eq(store_data_q[i], exp_data_q[i], $sformatf("store %0d data", i));
        end
    endtask

    task automatic test_reset();
        begin_program();
        run_program();
    endtask

    task automatic test_alu_ops();
        logic [3:0]  r_ops [9] = '{4'b0000, 4'b1000, 4'b0001, 4'b0010, 4'b0100,
                                   4'b0101, 4'b1101, 4'b0110, 4'b0111};
        logic [2:0]  i_ops [5] = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
        logic [31:0] op_a [3]  = '{32'h8765_4321, 32'hffff_fffb, 32'h0000_0005};
        logic [31:0] op_b [3]  = '{32'h0000_0f13, 32'h0000_0007, 32'hffff_fff0};
        int          p;
        int          k;
        begin_program();
        for (p = 0; p < 3; p++) begin
            emit_li(5'd1, op_a[p]);
            emit_li(5'd2, op_b[p]);
            for (k = 0; k < 9; k++) begin
                emit_op_reg(r_ops[k], 5'd3, 5'd1, 5'd2);
                emit_store(5'd3, 1'b1);
            end
            for (k = 0; k < 5; k++) begin
                emit_op_imm(i_ops[k], 5'd4, 5'd1, op_b[p][11:0]);
                emit_store(5'd4, 1'b1);
            end
        end
        emit(enc_lui(20'habcde, 5'd5));
        xr[5] = 32'habcd_e000;
        emit_store(5'd5, 1'b1);
        run_program();
    endtask

    task automatic test_forwarding();
        begin_program();
        emit_op_imm(3'b000, 5'd1, 5'd0, 12'd100);
        emit_op_imm(3'b000, 5'd2, 5'd1, 12'd23);
        emit_op_reg(4'b0000, 5'd3, 5'd2, 5'd1);
        emit_op_reg(4'b0100, 5'd4, 5'd3, 5'd2);
        emit_store(5'd4, 1'b1);
        emit_op_reg(4'b0000, 5'd5, 5'd4, 5'd3);
        emit_op_imm(3'b000, 5'd1, 5'd5, 12'hff9);
        emit_op_reg(4'b0100, 5'd1, 5'd1, 5'd5);
        // store base forwarded from execute
        emit_op_imm(3'b000, 5'd31, 5'd31, 12'd0);
        emit_store(5'd1, 1'b1);
        emit_store(5'd5, 1'b1);
        emit_store(5'd3, 1'b1);
        // same rd in execute and writeback, newest must win
        emit_op_imm(3'b000, 5'd6, 5'd0, 12'd1);
        emit_op_imm(3'b000, 5'd6, 5'd6, 12'd2);
        emit_op_reg(4'b0000, 5'd7, 5'd6, 5'd6);
        emit_store(5'd7, 1'b1);
        run_program();
    endtask

    task automatic test_branches();
        logic [2:0]  br_f3 [8] = '{3'b000, 3'b000, 3'b001, 3'b001,
                                   3'b100, 3'b100, 3'b101, 3'b101};
        logic [31:0] br_a [8]  = '{32'd5, 32'd5, 32'd5, 32'd5,
                                   32'hffff_fffd, 32'd2, 32'd2, 32'hffff_fffd};
        logic [31:0] br_b [8]  = '{32'd5, 32'd6, 32'd6, 32'd5,
                                   32'd2, 32'hffff_fffd, 32'hffff_fffd, 32'd2};
        logic        taken;
        int          k;
        begin_program();
        emit_li(5'd6, 32'h0000_0666);
        emit_li(5'd7, 32'h0000_0777);
        emit_li(5'd8, 32'h0000_0888);
        for (k = 0; k < 8; k++) begin
            emit_li(5'd1, br_a[k]);
            emit_li(5'd2, br_b[k]);
            taken = branch_taken(br_f3[k], xr[1], xr[2]);
            emit(enc_b(13'd12, 5'd2, 5'd1, br_f3[k]));
            emit_store(5'd6, !taken);
            emit_store(5'd7, !taken);
            emit_store(5'd8, 1'b1);
        end
        // link is the jal address plus four
        xr[10] = RESET_PC + 32'(wp * 4) + 32'd4;
        emit(enc_jal(21'd12, 5'd10));
        emit_store(5'd6, 1'b0);
        emit_store(5'd7, 1'b0);
        emit_store(5'd10, 1'b1);
        run_program();
    endtask

    task automatic test_x0();
        begin_program();
        emit_li(5'd1, 32'h1234_5678);
        emit_op_imm(3'b000, 5'd0, 5'd1, 12'h055);
        emit_op_reg(4'b0000, 5'd0, 5'd1, 5'd1);
        // lui x0, model keeps x0 at zero
        emit(enc_lui(20'hfffff, 5'd0));
        emit_store(5'd0, 1'b1);
        emit_op_reg(4'b0000, 5'd3, 5'd0, 5'd0);
        emit_op_imm(3'b000, 5'd4, 5'd0, 12'd9);
        emit_store(5'd3, 1'b1);
        emit_store(5'd4, 1'b1);
        run_program();
    endtask

    task automatic test_random_imm();
        logic [2:0]  f3_pick [3] = '{3'b000, 3'b100, 3'b110};
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] imm;
        int          sel;
        int          k;
        begin_program();
        for (k = 1; k <= 4; k++) begin
            emit_li(5'(k), $urandom());
        end
        for (k = 0; k < 20; k++) begin
            rd  = 5'(32'd1 + $urandom_range(3, 0));
            rs1 = 5'(32'd1 + $urandom_range(3, 0));
            imm = 12'($urandom());
            sel = int'($urandom_range(2, 0));
            emit_op_imm(f3_pick[sel], rd, rs1, imm);
            emit_store(rd, 1'b1);
        end
        run_program();
    endtask

    initial begin
        int i;
        clk         = 1'b0;
        reset_i     = 1'b1;
        err_count   = 0;
        check_count = 0;
        seed_dummy  = $urandom(SEED);
        for (i = 0; i < 32; i++) begin
            xr[i] = 32'd0;
        end
        fill_imem();
        test_reset();
        test_alu_ops();
        test_forwarding();
        test_branches();
        test_x0();
        test_random_imm();
        $display("checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
